// ==== dv/block_controller_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module block_controller_assertions (
	input logic clk,
	input logic rst,
	input logic fire,
	input logic fire_q,
	input logic [tank_game_pkg::N_SLOTS-1:0] alive,
	input tank_game_pkg::coord_t tank_x
);

	// failures seen so far, polled by the testbench every cycle
	int fail_count = 0;

	// the tank moves in steps of two between even limits
	property x_even_in_range;
		@(posedge clk) disable iff (rst)
		(tank_x[0] == 1'b0) && (tank_x >= tank_game_pkg::X_MIN) &&
			(tank_x <= tank_game_pkg::X_MAX);
	endproperty

	// one fire edge can wake at most one slot
	property one_launch_per_cycle;
		@(posedge clk) disable iff (rst)
		$countones(alive & ~$past(alive)) <= 1;
	endproperty

	// a slot that just woke up needs fire high over a low fire history
	property launch_needs_fire_edge;
		@(posedge clk) disable iff (rst)
		(|(alive & ~$past(alive))) |-> ($past(fire) && !$past(fire_q));
	endproperty

	x_even_in_range_a: assert property (x_even_in_range)
	else begin
		$error("tank_x is odd or outside the wrap limits");
		fail_count++;
	end

	one_launch_per_cycle_a: assert property (one_launch_per_cycle)
	else begin
		$error("more than one tank bullet launched in one cycle");
		fail_count++;
	end

	launch_needs_fire_edge_a: assert property (launch_needs_fire_edge)
	else begin
		$error("tank bullet launched without a fire rising edge");
		fail_count++;
	end

endmodule

// internal alive bits and fire history are reached through the bind
bind tank_ctrl block_controller_assertions asrt_i (
	.clk    (clk),
	.rst    (rst),
	.fire   (fire),
	.fire_q (fire_q),
	.alive  (alive),
	.tank_x (tank_x)
);

`default_nettype wire

// ==== dv/tb_block_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_block_controller;

	localparam int CLK_PERIOD = 40;
	// about 6600 cycles of tests below, plus margin
	localparam int CYCLE_LIMIT = 9000;

	logic clk;
	logic rst;
	logic bright;
	logic left;
	logic right;
	logic fire;
	tank_game_pkg::coord_t hcount;
	tank_game_pkg::coord_t vcount;
	tank_game_pkg::color_t rgb;

	// reference game model
	tank_game_pkg::coord_t m_tank_x;
	logic m_fire_q;
	logic [tank_game_pkg::N_SLOTS-1:0] m_alive;
	tank_game_pkg::coord_t m_bx [tank_game_pkg::N_SLOTS];
	tank_game_pkg::coord_t m_by [tank_game_pkg::N_SLOTS];
	logic [tank_game_pkg::N_SLOTS-1:0] m_mon_alive [tank_game_pkg::N_MONSTERS];
	tank_game_pkg::coord_t m_mon_y [tank_game_pkg::N_MONSTERS][tank_game_pkg::N_SLOTS];

	int cycles;
	int seed_ret;

	block_controller dut_i (
		.clk    (clk),
		.rst    (rst),
		.bright (bright),
		.left   (left),
		.right  (right),
		.fire   (fire),
		.hcount (hcount),
		.vcount (vcount),
		.rgb    (rgb)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "%s", why);
	endtask

	// run limit
	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		fail_now("timeout, the test ran past its cycle limit");
	end

	task automatic reset_model();
		m_tank_x = tank_game_pkg::TANK_X_RESET;
		m_fire_q = 1'b0;
		m_alive  = '0;
		for (int s = 0; s < tank_game_pkg::N_SLOTS; s++) begin
			m_bx[s] = tank_game_pkg::TANK_X_RESET;
			m_by[s] = tank_game_pkg::TANK_Y;
		end
		for (int m = 0; m < tank_game_pkg::N_MONSTERS; m++) begin
			m_mon_alive[m] = '0;
			for (int s = 0; s < tank_game_pkg::N_SLOTS; s++) begin
				m_mon_y[m][s] = tank_game_pkg::MONSTER_Y;
			end
		end
	endtask

	task automatic step_model();
		logic pulse;
		int launch_slot;
		tank_game_pkg::coord_t nx;
		tank_game_pkg::coord_t y0;
		logic [tank_game_pkg::N_SLOTS-1:0] was;
		logic [tank_game_pkg::N_SLOTS-1:0] go;
		pulse = fire && !m_fire_q;
		nx = m_tank_x;
		launch_slot = -1;
		// fire beats right beats left, a lost press still freezes the tank
		if (pulse) begin
			for (int s = tank_game_pkg::N_SLOTS - 1; s >= 0; s--) begin
				if (!m_alive[s]) launch_slot = s;
			end
		end else if (right) begin
			if (m_tank_x == tank_game_pkg::X_MAX) nx = tank_game_pkg::X_MIN;
			else nx = m_tank_x + tank_game_pkg::TANK_STEP;
		end else if (left) begin
			if (m_tank_x == tank_game_pkg::X_MIN) nx = tank_game_pkg::X_MAX;
			else nx = m_tank_x - tank_game_pkg::TANK_STEP;
		end
		for (int s = 0; s < tank_game_pkg::N_SLOTS; s++) begin
			if (m_alive[s]) begin
				if (m_by[s] <= tank_game_pkg::TANK_BULLET_TOP) m_alive[s] = 1'b0;
				m_by[s] = m_by[s] - 1;
			end else begin
				// parked bullets ride along with the tank
				m_bx[s] = nx;
				m_by[s] = tank_game_pkg::TANK_Y;
				if (s == launch_slot) m_alive[s] = 1'b1;
			end
		end
		m_tank_x = nx;
		m_fire_q = fire;
		// monster streams, cadence keyed on slot 0 position
		for (int m = 0; m < tank_game_pkg::N_MONSTERS; m++) begin
			was = m_mon_alive[m];
			y0 = m_mon_y[m][0];
			go = '0;
			if (!was[0]) go[0] = 1'b1;
			if (!go[0] && !was[1] && y0 == tank_game_pkg::MONSTER_TRIG_1[m]) go[1] = 1'b1;
			if (go == '0 && !was[2] && y0 == tank_game_pkg::MONSTER_TRIG_2[m]) go[2] = 1'b1;
			for (int s = 0; s < tank_game_pkg::N_SLOTS; s++) begin
				if (was[s]) begin
					if (m_mon_y[m][s] >= tank_game_pkg::MONSTER_BULLET_BOTTOM) begin
						m_mon_alive[m][s] = 1'b0;
					end
					m_mon_y[m][s] = m_mon_y[m][s] + 1;
				end else begin
					m_mon_y[m][s] = tank_game_pkg::MONSTER_Y;
					if (go[s]) m_mon_alive[m][s] = 1'b1;
				end
			end
		end
	endtask

	// inputs are stable here, they only change on the falling edge
	always @(posedge clk) begin
		if (rst) reset_model();
		else step_model();
	end

	function automatic logic in_range(input int p, input int lo, input int hi);
		return (p >= lo) && (p <= hi);
	endfunction

	function automatic logic near(input int h, input int v, input int cx, input int cy,
		input int rx, input int ry);
		return in_range(h, cx - rx, cx + rx) && in_range(v, cy - ry, cy + ry);
	endfunction

	// colour picked from the model state for one pixel
	function automatic tank_game_pkg::color_t expected_color(input logic b, input int h,
		input int v);
		logic blue;
		logic green;
		logic red;
		int tx;
		int ty;
		int mx;
		tank_game_pkg::color_t c;
		blue = 1'b0;
		red = 1'b0;
		tx = int'(m_tank_x);
		ty = int'(tank_game_pkg::TANK_Y);
		for (int s = 0; s < tank_game_pkg::N_SLOTS; s++) begin
			if (near(h, v, int'(m_bx[s]), int'(m_by[s]), tank_game_pkg::BULLET_R,
				tank_game_pkg::BULLET_R)) blue = 1'b1;
		end
		// head is the five rows above the body
		green = (in_range(v, ty - tank_game_pkg::TANK_HEAD_H, ty - 1) &&
			in_range(h, tx - tank_game_pkg::TANK_HEAD_HW, tx + tank_game_pkg::TANK_HEAD_HW)) ||
			(in_range(v, ty, ty + tank_game_pkg::TANK_BODY_H) &&
			in_range(h, tx - tank_game_pkg::TANK_BODY_HW, tx + tank_game_pkg::TANK_BODY_HW));
		for (int m = 0; m < tank_game_pkg::N_MONSTERS; m++) begin
			mx = int'(tank_game_pkg::MONSTER_X[m]);
			if (near(h, v, mx, int'(tank_game_pkg::MONSTER_Y), tank_game_pkg::MONSTER_HW,
				tank_game_pkg::MONSTER_HH)) red = 1'b1;
			for (int s = 0; s < tank_game_pkg::N_SLOTS; s++) begin
				if (near(h, v, mx, int'(m_mon_y[m][s]), tank_game_pkg::BULLET_R,
					tank_game_pkg::BULLET_R)) red = 1'b1;
			end
		end
		if (!b) c = tank_game_pkg::BLACK;
		else if (blue) c = tank_game_pkg::BLUE;
		else if (green) c = tank_game_pkg::GREEN;
		else if (red) c = tank_game_pkg::RED;
		else c = tank_game_pkg::BLACK;
		return c;
	endfunction

	task automatic check_rgb(input tank_game_pkg::color_t got, input tank_game_pkg::color_t exp);
		if (got !== exp) begin
			$display("** Error: rgb = %h, expected %h (hcount %h, vcount %h)",
				got, exp, hcount, vcount);
			fail_now("rgb does not match the model");
		end
	endtask

	// called at a falling edge, returns at the next one
	task automatic drive_and_check(input logic l, input logic r, input logic f,
		input logic b, input int h, input int v);
		left   = l;
		right  = r;
		fire   = f;
		bright = b;
		hcount = h[9:0];
		vcount = v[9:0];
		#(CLK_PERIOD/4);
		check_rgb(rgb, expected_color(b, int'(hcount), int'(vcount)));
		if (dut_i.tank_i.asrt_i.fail_count != 0) begin
			fail_now("an assertion on the tank controller failed");
		end
		@(negedge clk);
	endtask

	function automatic int jitter(input int r);
		return int'($urandom_range(0, 2 * r)) - r;
	endfunction

	initial begin
		rst    = 1'b1;
		bright = 1'b0;
		left   = 1'b0;
		right  = 1'b0;
		fire   = 1'b0;
		hcount = '0;
		vcount = '0;
		seed_ret = $urandom(7);
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// idle screen after reset, probe body centre and one monster
		drive_and_check(0, 0, 0, 1, m_tank_x, tank_game_pkg::TANK_Y + 5);
		check_rgb(rgb, tank_game_pkg::GREEN);
		drive_and_check(0, 0, 0, 1, tank_game_pkg::MONSTER_X[2], tank_game_pkg::MONSTER_Y);
		check_rgb(rgb, tank_game_pkg::RED);
		for (int i = 0; i < 20; i++) begin
			drive_and_check(0, 0, 0, 0, m_tank_x + jitter(10), tank_game_pkg::TANK_Y + jitter(8));
			check_rgb(rgb, tank_game_pkg::BLACK);
		end

		// tank motion, random levels then forced runs through both wraps
		for (int i = 0; i < 2000; i++) begin
			drive_and_check(i >= 1600 ? 1'b1 : (i < 1200 ? $urandom_range(0, 1) : 1'b0),
				(i >= 1200 && i < 1600) ? 1'b1 : (i < 1200 ? $urandom_range(0, 1) : 1'b0),
				0, 1, m_tank_x + jitter(2), tank_game_pkg::TANK_Y - $urandom_range(1, 5));
		end

		// fire held high launches once, then four quick presses
		for (int i = 0; i < 30; i++) begin
			drive_and_check(0, 0, 1, 1, m_bx[i % 3] + jitter(1), m_by[i % 3] + jitter(1));
		end
		for (int i = 0; i < 13; i++) begin
			drive_and_check(0, 0, (i < 8) && (i % 2 == 1), 1, m_bx[i % 3], m_by[i % 3]);
		end
		// follow every slot up to the top and past retirement
		for (int i = 0; i < 460; i++) begin
			drive_and_check($urandom_range(0, 1), 0, 0, 1, m_bx[i % 3] + jitter(1),
				m_by[i % 3] + jitter(1));
		end

		// monster cadence, rotate the probe over all 15 streams
		for (int i = 0; i < 1500; i++) begin
			drive_and_check(0, 0, 0, 1, tank_game_pkg::MONSTER_X[i % 5] + jitter(1),
				m_mon_y[i % 5][(i / 5) % 3] + jitter(1));
		end

		// everything random, half the probes around the tank
		for (int i = 0; i < 2500; i++) begin
			if (i % 2 == 0) begin
				drive_and_check($urandom_range(0, 1), $urandom_range(0, 1),
					$urandom_range(0, 3) == 0, $urandom_range(0, 7) != 0,
					m_tank_x + jitter(12), tank_game_pkg::TANK_Y + jitter(12));
			end else begin
				drive_and_check($urandom_range(0, 1), $urandom_range(0, 1),
					$urandom_range(0, 3) == 0, $urandom_range(0, 7) != 0,
					$urandom_range(0, 799), $urandom_range(0, 524));
			end
		end

		if (dut_i.tank_i.asrt_i.fail_count != 0) begin
			fail_now("an assertion on the tank controller failed");
		end else begin
			$display("TEST OK");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== hw/block_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module block_controller (
	input  logic clk,
	input  logic rst,
	// high inside the visible area
	input  logic bright,
	// move levels, sampled every cycle
	input  logic left,
	input  logic right,
	// fire button, acts on its rising edge
	input  logic fire,
	// current pixel from the sync generator
	input  tank_game_pkg::coord_t hcount,
	input  tank_game_pkg::coord_t vcount,
	output tank_game_pkg::color_t rgb
);

	// tank state toward the renderer
	tank_game_pkg::coord_t tank_x;
	tank_game_pkg::coord_t [tank_game_pkg::N_SLOTS-1:0] tank_bullet_x;
	tank_game_pkg::coord_t [tank_game_pkg::N_SLOTS-1:0] tank_bullet_y;

	// one row of slots per monster
	tank_game_pkg::coord_t [tank_game_pkg::N_MONSTERS-1:0][tank_game_pkg::N_SLOTS-1:0]
		monster_bullet_y;

	// player tank and its three bullets
	tank_ctrl tank_i (
		.clk           (clk),
		.rst           (rst),
		.left          (left),
		.right         (right),
		.fire          (fire),
		.tank_x        (tank_x),
		.tank_bullet_x (tank_bullet_x),
		.tank_bullet_y (tank_bullet_y)
	);

	// one gun per monster, cadence taken from the monster table
	for (genvar m = 0; m < tank_game_pkg::N_MONSTERS; m++) begin : g_monster
		monster_gun #(
			.TRIG_1 (tank_game_pkg::MONSTER_TRIG_1[m]),
			.TRIG_2 (tank_game_pkg::MONSTER_TRIG_2[m])
		) gun_i (
			.clk      (clk),
			.rst      (rst),
			.bullet_y (monster_bullet_y[m])
		);
	end

	// colour of the current pixel, no pipeline
	sprite_render render_i (
		.bright           (bright),
		.hcount           (hcount),
		.vcount           (vcount),
		.tank_x           (tank_x),
		.tank_bullet_x    (tank_bullet_x),
		.tank_bullet_y    (tank_bullet_y),
		.monster_bullet_y (monster_bullet_y),
		.rgb              (rgb)
	);

endmodule

`default_nettype wire

// ==== hw/monster_gun.sv ====
`timescale 1ns/1ps
`default_nettype none

module monster_gun #(
	// slot 0 rows at which slots 1 and 2 may fire
	parameter tank_game_pkg::coord_t TRIG_1 = 10'd250,
	parameter tank_game_pkg::coord_t TRIG_2 = 10'd450
) (
	input  logic clk,
	input  logic rst,
	output tank_game_pkg::coord_t [tank_game_pkg::N_SLOTS-1:0] bullet_y
);

	// slot state, bit set while the bullet falls
	logic [tank_game_pkg::N_SLOTS-1:0] alive;
	// at most one slot launches per cycle
	logic [tank_game_pkg::N_SLOTS-1:0] launch;
	// falling slots at or past the bottom row
	logic [tank_game_pkg::N_SLOTS-1:0] retire;

	// cadence comes from where slot 0 is
	// slot 0 refires as soon as it is back home
	always_comb begin
		launch = '0;
		if (!alive[0]) begin
			launch[0] = 1'b1;
		end else if (!alive[1] && (bullet_y[0] == TRIG_1)) begin
			launch[1] = 1'b1;
		end else if (!alive[2] && (bullet_y[0] == TRIG_2)) begin
			launch[2] = 1'b1;
		end
	end

	always_comb begin
		for (int i = 0; i < tank_game_pkg::N_SLOTS; i++) begin
			retire[i] = alive[i] &&
				(bullet_y[i] >= tank_game_pkg::MONSTER_BULLET_BOTTOM);
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			alive <= '0;
			for (int i = 0; i < tank_game_pkg::N_SLOTS; i++) begin
				bullet_y[i] <= tank_game_pkg::MONSTER_Y;
			end
		end else begin
			alive <= (alive | launch) & ~retire;
			for (int i = 0; i < tank_game_pkg::N_SLOTS; i++) begin
				if (alive[i]) begin
					// one row down per cycle
					bullet_y[i] <= bullet_y[i] + 1'b1;
				end else begin
					// parked on the monster until launched
					bullet_y[i] <= tank_game_pkg::MONSTER_Y;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/sprite_render.sv ====
`timescale 1ns/1ps
`default_nettype none

module sprite_render (
	input  logic bright,
	input  tank_game_pkg::coord_t hcount,
	input  tank_game_pkg::coord_t vcount,
	input  tank_game_pkg::coord_t tank_x,
	input  tank_game_pkg::coord_t [tank_game_pkg::N_SLOTS-1:0] tank_bullet_x,
	input  tank_game_pkg::coord_t [tank_game_pkg::N_SLOTS-1:0] tank_bullet_y,
	input  tank_game_pkg::coord_t [tank_game_pkg::N_MONSTERS-1:0][tank_game_pkg::N_SLOTS-1:0]
		monster_bullet_y,
	output tank_game_pkg::color_t rgb
);

	// pixel over any tank bullet
	logic hit_tank_bullet;
	logic hit_tank_head;
	logic hit_tank_body;
	// pixel over any monster body
	logic hit_monster;
	// pixel over any of the 15 monster bullets
	logic hit_monster_bullet;

	// true when c+lo <= p <= c+hi, bounds inclusive
	// signed int math so offsets below zero never wrap
	function automatic logic in_span(
		input tank_game_pkg::coord_t p,
		input tank_game_pkg::coord_t c,
		input int lo,
		input int hi
	);
		return (int'(p) >= int'(c) + lo) && (int'(p) <= int'(c) + hi);
	endfunction

	// tank, head rows sit just above the body
	assign hit_tank_head =
		in_span(vcount, tank_game_pkg::TANK_Y, -tank_game_pkg::TANK_HEAD_H, -1) &&
		in_span(hcount, tank_x, -tank_game_pkg::TANK_HEAD_HW, tank_game_pkg::TANK_HEAD_HW);
	assign hit_tank_body =
		in_span(vcount, tank_game_pkg::TANK_Y, 0, tank_game_pkg::TANK_BODY_H) &&
		in_span(hcount, tank_x, -tank_game_pkg::TANK_BODY_HW, tank_game_pkg::TANK_BODY_HW);

	// tank bullets, 3x3 squares
	always_comb begin
		hit_tank_bullet = 1'b0;
		for (int s = 0; s < tank_game_pkg::N_SLOTS; s++) begin
			if (in_span(hcount, tank_bullet_x[s], -tank_game_pkg::BULLET_R,
					tank_game_pkg::BULLET_R) &&
				in_span(vcount, tank_bullet_y[s], -tank_game_pkg::BULLET_R,
					tank_game_pkg::BULLET_R)) begin
				hit_tank_bullet = 1'b1;
			end
		end
	end

	// monsters and their bullets
	// monster columns are fixed, bullets fall straight down the same column
	always_comb begin
		hit_monster        = 1'b0;
		hit_monster_bullet = 1'b0;
		for (int m = 0; m < tank_game_pkg::N_MONSTERS; m++) begin
			if (in_span(hcount, tank_game_pkg::MONSTER_X[m], -tank_game_pkg::MONSTER_HW,
					tank_game_pkg::MONSTER_HW) &&
				in_span(vcount, tank_game_pkg::MONSTER_Y, -tank_game_pkg::MONSTER_HH,
					tank_game_pkg::MONSTER_HH)) begin
				hit_monster = 1'b1;
			end
			for (int s = 0; s < tank_game_pkg::N_SLOTS; s++) begin
				if (in_span(hcount, tank_game_pkg::MONSTER_X[m], -tank_game_pkg::BULLET_R,
						tank_game_pkg::BULLET_R) &&
					in_span(vcount, monster_bullet_y[m][s], -tank_game_pkg::BULLET_R,
						tank_game_pkg::BULLET_R)) begin
					hit_monster_bullet = 1'b1;
				end
			end
		end
	end

	// priority: blanking, tank bullets, tank, monster side, background
	always_comb begin
		if (!bright) begin
			rgb = tank_game_pkg::BLACK;
		end else if (hit_tank_bullet) begin
			rgb = tank_game_pkg::BLUE;
		end else if (hit_tank_head || hit_tank_body) begin
			rgb = tank_game_pkg::GREEN;
		end else if (hit_monster || hit_monster_bullet) begin
			rgb = tank_game_pkg::RED;
		end else begin
			rgb = tank_game_pkg::BLACK;
		end
	end

endmodule

`default_nettype wire

// ==== hw/tank_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tank_ctrl (
	input  logic clk,
	input  logic rst,
	input  logic left,
	input  logic right,
	input  logic fire,
	output tank_game_pkg::coord_t tank_x,
	output tank_game_pkg::coord_t [tank_game_pkg::N_SLOTS-1:0] tank_bullet_x,
	output tank_game_pkg::coord_t [tank_game_pkg::N_SLOTS-1:0] tank_bullet_y
);

	// fire level seen at the previous edge
	logic fire_q;
	// one cycle high on a fire rising edge
	logic fire_pulse;

	// slot state, bit set while the bullet is in flight
	logic [tank_game_pkg::N_SLOTS-1:0] alive;
	logic [tank_game_pkg::N_SLOTS-1:0] free;
	// one-hot, lowest free slot when fire is pressed
	logic [tank_game_pkg::N_SLOTS-1:0] launch;
	// in-flight slots that reached the top this cycle
	logic [tank_game_pkg::N_SLOTS-1:0] retire;

	// tank x after this edge
	tank_game_pkg::coord_t x_next;

	// rising edge detect, no debounce
	assign fire_pulse = fire & ~fire_q;

	assign free = ~alive;

	// isolate the lowest set bit of free
	// all zero when every slot is busy, so the press is simply lost
	assign launch = fire_pulse ? (free & (~free + 1'b1)) : '0;

	always_comb begin
		for (int i = 0; i < tank_game_pkg::N_SLOTS; i++) begin
			retire[i] = alive[i] && (tank_bullet_y[i] <= tank_game_pkg::TANK_BULLET_TOP);
		end
	end

	// movement, fire pulse has priority over right, right over left
	// a pulse that finds no free slot still blocks the move
	always_comb begin
		x_next = tank_x;
		if (!fire_pulse) begin
			if (right) begin
				// wrap from the right edge back to the left edge
				if (tank_x == tank_game_pkg::X_MAX) begin
					x_next = tank_game_pkg::X_MIN;
				end else begin
					x_next = tank_x + tank_game_pkg::TANK_STEP;
				end
			end else if (left) begin
				if (tank_x == tank_game_pkg::X_MIN) begin
					x_next = tank_game_pkg::X_MAX;
				end else begin
					x_next = tank_x - tank_game_pkg::TANK_STEP;
				end
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			tank_x <= tank_game_pkg::TANK_X_RESET;
			fire_q <= 1'b0;
			alive  <= '0;
			// idle bullets park on the tank centre
			for (int i = 0; i < tank_game_pkg::N_SLOTS; i++) begin
				tank_bullet_x[i] <= tank_game_pkg::TANK_X_RESET;
				tank_bullet_y[i] <= tank_game_pkg::TANK_Y;
			end
		end else begin
			tank_x <= x_next;
			fire_q <= fire;
			// launch only hits free slots and retire only busy ones
			alive  <= (alive | launch) & ~retire;
			for (int i = 0; i < tank_game_pkg::N_SLOTS; i++) begin
				if (alive[i]) begin
					// in flight, column frozen, one row up per cycle
					tank_bullet_y[i] <= tank_bullet_y[i] - 1'b1;
				end else begin
					// free slot follows the tank so a launch starts at its centre
					tank_bullet_x[i] <= x_next;
					tank_bullet_y[i] <= tank_game_pkg::TANK_Y;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/tank_game_pkg.sv ====
`default_nettype none

package tank_game_pkg;

	// screen coordinate, wide enough for an 800 x 525 raster
	typedef logic [9:0] coord_t;

	// 4:4:4 rgb, red in the top nibble
	typedef logic [11:0] color_t;

	// bullet slots per shooter
	localparam int N_SLOTS    = 3;
	localparam int N_MONSTERS = 5;

	// tank row and horizontal travel
	localparam coord_t TANK_Y       = 10'd450;
	localparam coord_t TANK_X_RESET = 10'd450;
	localparam coord_t TANK_STEP    = 10'd2;
	// wrap limits, both even so the tank x stays even
	localparam coord_t X_MIN = 10'd150;
	localparam coord_t X_MAX = 10'd800;

	// all monsters share one row
	localparam coord_t MONSTER_Y = 10'd100;

	// retirement rows for upward and downward bullets
	localparam coord_t TANK_BULLET_TOP       = 10'd33;
	localparam coord_t MONSTER_BULLET_BOTTOM = 10'd514;

	// sprite extents in pixels
	// head sits on top of the body, body starts at the tank row
	localparam int TANK_HEAD_H  = 5;
	localparam int TANK_HEAD_HW = 2;
	localparam int TANK_BODY_H  = 10;
	localparam int TANK_BODY_HW = 10;
	localparam int MONSTER_HH   = 5;
	localparam int MONSTER_HW   = 10;
	localparam int BULLET_R     = 1;

	// palette
	localparam color_t BLACK = 12'h000;
	localparam color_t GREEN = 12'h0f0;
	localparam color_t BLUE  = 12'h00f;
	localparam color_t RED   = 12'hf00;

	// per monster: column, then the slot 0 rows that trigger slots 1 and 2
	localparam coord_t MONSTER_X [N_MONSTERS] =
		'{10'd250, 10'd350, 10'd450, 10'd550, 10'd650};
	localparam coord_t MONSTER_TRIG_1 [N_MONSTERS] =
		'{10'd250, 10'd180, 10'd250, 10'd200, 10'd260};
	localparam coord_t MONSTER_TRIG_2 [N_MONSTERS] =
		'{10'd450, 10'd380, 10'd450, 10'd400, 10'd460};

endpackage

`default_nettype wire

// ==== tank_game.f ====
hw/tank_game_pkg.sv
hw/tank_ctrl.sv
hw/monster_gun.sv
hw/sprite_render.sv
hw/block_controller.sv
dv/block_controller_assertions.sv
dv/tb_block_controller.sv
